//--- logic/cast_defs.svh
`ifndef CAST_DEFS_SVH
`define CAST_DEFS_SVH

// --------------------------------------------------
// binary32 layout
// --------------------------------------------------
`define CAST_FP_WIDTH   32  // Total float width
`define CAST_EXP_BITS   8   // Exponent field
`define CAST_MAN_BITS   23  // Stored mantissa, hidden bit excluded
`define CAST_BIAS       127 // Exponent bias

// --------------------------------------------------
// Integer side and internal datapath
// --------------------------------------------------
`define CAST_INT_WIDTH  32  // Only int32 / uint32

// Mantissa with hidden bit or a full integer, whichever is wider
`define CAST_MANT_WIDTH 32
`define CAST_EXP_WIDTH  10  // Signed, covers smallest subnormal
`define CAST_LZC_WIDTH  5   // log2 of internal mantissa width

`endif

//--- logic/cast_fmt_pkg.sv
`include "cast_defs.svh"

package cast_fmt_pkg;

  // Float fields as they sit in the operand word
  typedef struct packed {
    logic                      sign;
    logic [`CAST_EXP_BITS-1:0] exponent;
    logic [`CAST_MAN_BITS-1:0] mantissa;
  } fp32_t;

  // One-hot-ish classification of a float source
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling; // NaN with quiet bit clear
  } fp_info_t;

  // IEEE exception flags, DZ never occurs in a cast
  typedef struct packed {
    logic NV; // Invalid
    logic OF; // Overflow
    logic UF; // Underflow
    logic NX; // Inexact
  } status_t;

  // Decode exponent and mantissa into class bits
  function automatic fp_info_t classify(fp32_t val);
    fp_info_t info;
    logic     exp_ones;
    logic     exp_zero;
    logic     man_zero;
    exp_ones           = &val.exponent;
    exp_zero           = ~|val.exponent;
    man_zero           = ~|val.mantissa;
    info.is_normal     = ~exp_zero & ~exp_ones;
    info.is_subnormal  = exp_zero & ~man_zero;
    info.is_zero       = exp_zero & man_zero;
    info.is_inf        = exp_ones & man_zero;
    info.is_nan        = exp_ones & ~man_zero;
    info.is_signalling = info.is_nan & ~val.mantissa[`CAST_MAN_BITS-1]; // MSB is quiet bit
    return info;
  endfunction

endpackage

//--- logic/cast_op_pkg.sv
`include "cast_defs.svh"

package cast_op_pkg;

  typedef enum logic {
    CAST_I2F = 1'b0, // Integer source, float result
    CAST_F2I = 1'b1  // Float source, integer result
  } cast_op_e;

  // Encoding follows the usual RISC-V frm values
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } round_mode_e;

  typedef struct packed {
    logic [`CAST_FP_WIDTH-1:0] operand;     // Float bits or integer
    cast_op_e                  op;
    logic                      is_unsigned; // Integer side is unsigned
    round_mode_e               rnd_mode;
  } cast_req_t;

  // Contents of the stage-1 register
  typedef struct packed {
    logic                              sign;
    logic [`CAST_MANT_WIDTH-1:0]       mant;    // MSB set unless zero
    logic signed [`CAST_EXP_WIDTH-1:0] exp;     // Unbiased
    logic signed [`CAST_EXP_WIDTH-1:0] dst_exp; // Rebiased for binary32
    cast_op_e                          op;
    logic                              is_unsigned;
    round_mode_e                       rnd_mode;
    cast_fmt_pkg::fp_info_t            info;    // Zero for integer sources
    logic                              mant_zero;
  } norm_stage_t;

  typedef struct packed {
    logic [`CAST_FP_WIDTH-1:0] result;
    cast_fmt_pkg::status_t     status;
  } cast_res_t;

endpackage

//--- logic/cast_pipe_ctrl.sv
module cast_pipe_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  logic flush_i,
  input  logic out_ready_i,
  output logic out_valid_o,
  output logic busy_o,
  output logic ld_norm_o, // Load stage-1 register
  output logic ld_out_o   // Load output register
);

  logic norm_valid_q; // Stage 1 holds an item
  logic out_valid_q;  // Output register holds an item
  logic run_q;        // Set one cycle after reset release
  logic out_rdy;
  logic norm_rdy;

  // Ready travels backwards so a bubble can always be overwritten
  assign out_rdy  = out_ready_i | ~out_valid_q;
  assign norm_rdy = out_rdy | ~norm_valid_q;

  assign in_ready_o  = norm_rdy & run_q;
  assign ld_norm_o   = in_ready_o & in_valid_i;
  assign ld_out_o    = out_rdy & norm_valid_q;
  assign out_valid_o = out_valid_q;
  assign busy_o      = norm_valid_q | out_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      norm_valid_q <= 1'b0;
      out_valid_q  <= 1'b0;
      run_q        <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (flush_i) begin // Drop everything in flight
        norm_valid_q <= 1'b0;
        out_valid_q  <= 1'b0;
      end else begin
        if (norm_rdy) norm_valid_q <= ld_norm_o;
        if (out_rdy)  out_valid_q  <= norm_valid_q;
      end
    end
  end

  // A presented result is held until taken
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o);

  // Output register only loads items that entered or stayed in stage 1
  a_ld_out_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ld_out_o |-> $past(ld_norm_o || norm_valid_q));

endmodule

//--- logic/cast_normalize.sv
`include "cast_defs.svh"

module cast_normalize (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  cast_op_pkg::cast_req_t   req_i,
  input  logic                     ld_i,
  output cast_op_pkg::norm_stage_t norm_o
);
  import cast_fmt_pkg::*;
  import cast_op_pkg::*;

  localparam int unsigned MW   = `CAST_MANT_WIDTH;
  localparam int unsigned EW   = `CAST_EXP_WIDTH;
  localparam int unsigned LW   = `CAST_LZC_WIDTH;
  localparam int unsigned COMP = `CAST_MANT_WIDTH - 1 - `CAST_MAN_BITS; // Float mant sits at LSB

  fp32_t                  src_fp;
  fp_info_t               info;
  logic                   is_int;
  logic                   int_sign;
  logic [MW-1:0]          int_mag;
  logic [MW-1:0]          enc_mant;  // Mantissa before normalization
  logic [LW-1:0]          lzc_cnt;
  logic signed [EW-1:0]   fp_exp;
  logic signed [EW-1:0]   int_exp;
  logic signed [EW-1:0]   unb_exp;
  norm_stage_t            norm_d;

  // --------------------------------------------------
  // Source decode
  // --------------------------------------------------
  assign src_fp   = fp32_t'(req_i.operand);
  assign info     = classify(src_fp);
  assign is_int   = (req_i.op == CAST_I2F);
  assign int_sign = req_i.operand[`CAST_INT_WIDTH-1] & ~req_i.is_unsigned; // Signed only
  assign int_mag  = int_sign ? MW'(-req_i.operand) : MW'(req_i.operand);
  assign enc_mant = is_int ? int_mag : MW'({info.is_normal, src_fp.mantissa});

  // Leading-zero count, highest set bit wins
  always_comb begin : lzc
    lzc_cnt = '0;
    for (int i = 0; i < MW; i++) begin
      if (enc_mant[i]) lzc_cnt = LW'(MW - 1 - i);
    end
  end

  // Unbias and undo the normalizing shift
  assign fp_exp  = $signed(EW'(src_fp.exponent)) + $signed(EW'(info.is_subnormal))
                 - $signed(EW'(`CAST_BIAS)) - $signed(EW'(lzc_cnt)) + $signed(EW'(COMP));
  assign int_exp = $signed(EW'(MW - 1)) - $signed(EW'(lzc_cnt));
  assign unb_exp = is_int ? int_exp : fp_exp;

  always_comb begin : build_stage
    norm_d             = '0;
    norm_d.sign        = is_int ? int_sign : src_fp.sign;
    norm_d.mant        = enc_mant << lzc_cnt; // MSB now set
    norm_d.exp         = unb_exp;
    norm_d.dst_exp     = unb_exp + $signed(EW'(`CAST_BIAS)); // binary32 bias
    norm_d.op          = req_i.op;
    norm_d.is_unsigned = req_i.is_unsigned;
    norm_d.rnd_mode    = req_i.rnd_mode;
    norm_d.info        = is_int ? '0 : info; // Class only means something for floats
    norm_d.mant_zero   = (enc_mant == '0);
  end

  // Stage-1 register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)  norm_o <= '0;
    else if (ld_i) norm_o <= norm_d;
  end

  a_op_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ld_i |-> !$isunknown(req_i.op));

endmodule

//--- logic/cast_align.sv
`include "cast_defs.svh"

module cast_align (
  input  cast_op_pkg::norm_stage_t   norm_i,
  output logic [`CAST_EXP_BITS-1:0]  final_exp_o,
  output logic [`CAST_MAN_BITS-1:0]  final_mant_o,
  output logic [`CAST_INT_WIDTH-1:0] final_int_o,
  output logic [1:0]                 round_sticky_o, // {round, sticky}
  output logic                       of_before_o,
  output logic                       uf_before_o
);
  import cast_op_pkg::*;

  localparam int unsigned MW = `CAST_MANT_WIDTH;
  localparam int unsigned EW = `CAST_EXP_WIDTH;
  localparam int unsigned IW = `CAST_INT_WIDTH;
  localparam int unsigned MB = `CAST_MAN_BITS;
  localparam int unsigned SW = $clog2(MW + 2);
  localparam int unsigned FP_STICKY  = 2 * MW - MB - 1; // Below mantissa and round bit
  localparam int unsigned INT_STICKY = 2 * MW - IW;

  logic signed [EW-1:0] exp;
  logic signed [EW-1:0] dexp;
  logic signed [EW-1:0] of_lim;   // Unsigned range is one bit wider
  logic [2*MW:0]        preshift; // Mantissa at the top with room below
  logic [2*MW:0]        dest;
  logic [SW-1:0]        shamt;
  logic [1:0]           fp_rs;
  logic [1:0]           int_rs;

  assign exp    = norm_i.exp;
  assign dexp   = norm_i.dst_exp;
  assign of_lim = $signed(EW'(IW - 1)) + $signed(EW'(norm_i.is_unsigned));

  always_comb begin : cast_value
    final_exp_o = dexp[`CAST_EXP_BITS-1:0]; // Low bits only
    preshift    = {norm_i.mant, (MW + 1)'(0)};
    shamt       = '0;
    of_before_o = 1'b0;
    uf_before_o = 1'b0;
    if (norm_i.op == CAST_F2I) begin
      shamt = SW'(IW - 1 - exp); // Binary point to int LSB
      if (exp >= of_lim) begin
        shamt       = '0;
        of_before_o = 1'b1;
      end else if (exp < -1) begin
        shamt       = SW'(IW + 1); // Everything lands in sticky
        uf_before_o = 1'b1;
      end
    end else begin
      if (dexp >= 255) begin
        final_exp_o = 8'hfe; // Largest finite so rounding decides inf
        preshift    = '1;
        of_before_o = 1'b1;
      end else if (dexp < 1 && dexp >= -$signed(EW'(MB))) begin
        final_exp_o = '0;     // Subnormal result
        shamt       = SW'(1 - dexp);
        uf_before_o = 1'b1;
      end else if (dexp < -$signed(EW'(MB))) begin
        final_exp_o = '0;
        shamt       = SW'(MB + 2); // Cap so sticky survives
        uf_before_o = 1'b1;
      end
    end
  end

  assign dest = preshift >> shamt;

  // Hidden bit at the very top is dropped for floats
  assign {final_mant_o, fp_rs[1]} = dest[2*MW-1 -: MB+1];
  assign {final_int_o, int_rs[1]} = dest[2*MW -: IW+1];
  assign fp_rs[0]  = |dest[FP_STICKY-1:0];
  assign int_rs[0] = |dest[INT_STICKY-1:0];

  assign round_sticky_o = (norm_i.op == CAST_F2I) ? int_rs : fp_rs;

endmodule

//--- logic/cast_round_pack.sv
`include "cast_defs.svh"

module cast_round_pack (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       ld_i,
  input  cast_op_pkg::norm_stage_t   norm_i,
  input  logic [`CAST_EXP_BITS-1:0]  final_exp_i,
  input  logic [`CAST_MAN_BITS-1:0]  final_mant_i,
  input  logic [`CAST_INT_WIDTH-1:0] final_int_i,
  input  logic [1:0]                 round_sticky_i,
  input  logic                       of_before_i,
  input  logic                       uf_before_i,
  output cast_op_pkg::cast_res_t     res_o
);
  import cast_fmt_pkg::*;
  import cast_op_pkg::*;

  localparam int unsigned IW  = `CAST_INT_WIDTH;
  localparam int unsigned FPW = `CAST_FP_WIDTH;

  logic             to_int;
  logic [IW-1:0]    pre_abs;
  logic             round_up;
  logic [IW-1:0]    rnd_abs;
  logic [IW-1:0]    int_val;     // Two's complement of rounded value
  logic [IW-1:0]    int_special;
  logic             int_is_special;
  logic             of_after;
  logic             tiny;
  status_t          int_status;
  status_t          fp_status;
  logic [FPW-1:0]   fp_val;
  cast_res_t        res_d;
  cast_res_t        res_q;

  assign to_int  = (norm_i.op == CAST_F2I);
  assign pre_abs = to_int ? final_int_i : IW'({final_exp_i, final_mant_i});

  // --------------------------------------------------
  // Rounding
  // --------------------------------------------------
  always_comb begin : rnd
    case (norm_i.rnd_mode)
      RNE:     round_up = round_sticky_i[1] & (round_sticky_i[0] | pre_abs[0]); // Tie to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky_i) & norm_i.sign;
      RUP:     round_up = (|round_sticky_i) & ~norm_i.sign;
      RMM:     round_up = round_sticky_i[1]; // Tie away
      default: round_up = 1'b0;
    endcase
  end

  assign rnd_abs = pre_abs + IW'(round_up);

  // --------------------------------------------------
  // F2I result and specials
  // --------------------------------------------------
  assign int_val = norm_i.sign ? IW'(-rnd_abs) : rnd_abs;

  always_comb begin : int_spec
    int_special         = {norm_i.is_unsigned, {(IW-1){1'b1}}}; // Positive max
    if (norm_i.sign && !norm_i.info.is_nan)
      int_special = ~int_special; // Min or 0
  end

  // NaN, inf, range overflow, or a nonzero negative going unsigned
  assign int_is_special = norm_i.info.is_nan | norm_i.info.is_inf | of_before_i |
                          (norm_i.sign & norm_i.is_unsigned & (int_val != '0));
  assign int_status     = int_is_special ? '{NV: 1'b1, default: 1'b0}
                                         : '{NX: |round_sticky_i, default: 1'b0};

  // --------------------------------------------------
  // I2F result and flags
  // --------------------------------------------------
  assign of_after     = &rnd_abs[FPW-2 -: `CAST_EXP_BITS]; // Carried into inf exponent
  assign tiny         = uf_before_i | ~|rnd_abs[FPW-2 -: `CAST_EXP_BITS];
  assign fp_val       = norm_i.mant_zero ? '0 : {norm_i.sign, rnd_abs[FPW-2:0]}; // +0 for int 0
  assign fp_status.NV = 1'b0;
  assign fp_status.OF = of_before_i | of_after;
  assign fp_status.NX = (|round_sticky_i) | fp_status.OF;
  assign fp_status.UF = tiny & fp_status.NX;

  assign res_d.result = to_int ? (int_is_special ? int_special : int_val) : fp_val;
  assign res_d.status = to_int ? int_status : fp_status;

  // Output register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)  res_q <= '0;
    else if (ld_i) res_q <= res_d;
  end

  assign res_o = res_q;

endmodule

//--- logic/fp_cast_unit.sv
`include "cast_defs.svh"

module fp_cast_unit (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  cast_op_pkg::cast_req_t req_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  logic                   flush_i,
  output cast_op_pkg::cast_res_t res_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   busy_o
);
  import cast_op_pkg::*;

  logic                       ld_norm;
  logic                       ld_out;
  norm_stage_t                norm_q;     // Stage-1 register contents
  logic [`CAST_EXP_BITS-1:0]  final_exp;
  logic [`CAST_MAN_BITS-1:0]  final_mant;
  logic [`CAST_INT_WIDTH-1:0] final_int;
  logic [1:0]                 round_sticky;
  logic                       of_before;
  logic                       uf_before;

  // --------------------------------------------------
  // Handshake and stage control
  // --------------------------------------------------
  cast_pipe_ctrl cast_pipe_ctrl_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .busy_o      (busy_o),
    .ld_norm_o   (ld_norm),
    .ld_out_o    (ld_out)
  );

  // --------------------------------------------------
  // Datapath, normalize | align + round
  // --------------------------------------------------
  cast_normalize cast_normalize_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req_i),
    .ld_i    (ld_norm),
    .norm_o  (norm_q)
  );

  cast_align cast_align_i (
    .norm_i         (norm_q),
    .final_exp_o    (final_exp),
    .final_mant_o   (final_mant),
    .final_int_o    (final_int),
    .round_sticky_o (round_sticky),
    .of_before_o    (of_before),
    .uf_before_o    (uf_before)
  );

  cast_round_pack cast_round_pack_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ld_i           (ld_out),
    .norm_i         (norm_q),
    .final_exp_i    (final_exp),
    .final_mant_i   (final_mant),
    .final_int_i    (final_int),
    .round_sticky_i (round_sticky),
    .of_before_i    (of_before),
    .uf_before_i    (uf_before),
    .res_o          (res_o)
  );

endmodule

//--- sim/tb_fp_cast_unit.sv
`include "cast_defs.svh"

module tb_fp_cast_unit;
  timeunit 1ns;
  timeprecision 1ps;
  import cast_op_pkg::*;

  localparam int N_VEC = 23;
  localparam int LIMIT = 200; // Cycles before any wait gives up

  typedef struct packed {
    cast_op_e                  op;
    logic                      uns;     // Integer side unsigned
    round_mode_e               rm;
    logic [`CAST_FP_WIDTH-1:0] operand;
    logic [`CAST_FP_WIDTH-1:0] res;     // Expected result bits
    logic [3:0]                st;      // Expected {NV, OF, UF, NX}
  } vec_t;

  // --------------------------------------------------
  // op, unsigned, mode, operand, result, status
  // --------------------------------------------------
  localparam vec_t VECS [N_VEC] = '{
    '{CAST_I2F, 1'b0, RNE, 32'h0000_0001, 32'h3f80_0000, 4'h0}, // 1 -> 1.0
    '{CAST_I2F, 1'b0, RNE, 32'hffff_ffff, 32'hbf80_0000, 4'h0}, // -1 -> -1.0
    '{CAST_I2F, 1'b0, RNE, 32'h0100_0001, 32'h4b80_0000, 4'h1}, // 2^24+1, tie to even
    '{CAST_I2F, 1'b0, RTZ, 32'h0100_0001, 32'h4b80_0000, 4'h1},
    '{CAST_I2F, 1'b0, RUP, 32'h0100_0001, 32'h4b80_0001, 4'h1},
    '{CAST_I2F, 1'b0, RDN, 32'h0100_0001, 32'h4b80_0000, 4'h1},
    '{CAST_I2F, 1'b0, RNE, 32'h7fff_ffff, 32'h4f00_0000, 4'h1}, // Rounds up to 2^31
    '{CAST_I2F, 1'b0, RTZ, 32'h7fff_ffff, 32'h4eff_ffff, 4'h1},
    '{CAST_I2F, 1'b0, RDN, 32'h7fff_ffff, 32'h4eff_ffff, 4'h1},
    '{CAST_I2F, 1'b0, RUP, 32'h7fff_ffff, 32'h4f00_0000, 4'h1},
    '{CAST_I2F, 1'b0, RMM, 32'h7fff_ffff, 32'h4f00_0000, 4'h1},
    '{CAST_I2F, 1'b0, RNE, 32'h0000_0000, 32'h0000_0000, 4'h0}, // +0, no flags
    '{CAST_I2F, 1'b1, RNE, 32'hffff_ffff, 32'h4f80_0000, 4'h1}, // 2^32-1 unsigned
    '{CAST_F2I, 1'b0, RNE, 32'h4020_0000, 32'h0000_0002, 4'h1}, // 2.5
    '{CAST_F2I, 1'b0, RMM, 32'h4020_0000, 32'h0000_0003, 4'h1},
    '{CAST_F2I, 1'b0, RDN, 32'hc020_0000, 32'hffff_fffd, 4'h1}, // -2.5 -> -3
    '{CAST_F2I, 1'b0, RTZ, 32'h3ecc_cccd, 32'h0000_0000, 4'h1}, // 0.4
    '{CAST_F2I, 1'b0, RNE, 32'h7fc0_0000, 32'h7fff_ffff, 4'h8}, // qNaN
    '{CAST_F2I, 1'b0, RNE, 32'h7f80_0000, 32'h7fff_ffff, 4'h8}, // +inf
    '{CAST_F2I, 1'b0, RNE, 32'hff80_0000, 32'h8000_0000, 4'h8}, // -inf
    '{CAST_F2I, 1'b0, RNE, 32'h4f32_d05e, 32'h7fff_ffff, 4'h8}, // 3e9 out of int32
    '{CAST_F2I, 1'b1, RNE, 32'hbf80_0000, 32'h0000_0000, 4'h8}, // -1.0 to unsigned
    '{CAST_F2I, 1'b1, RNE, 32'h4f32_d05e, 32'hb2d0_5e00, 4'h0}  // 3e9 exact
  };

  logic      clk_i;
  logic      rst_n_i;
  cast_req_t req_i;
  logic      in_valid_i;
  logic      in_ready_o;
  logic      flush_i;
  cast_res_t res_o;
  logic      out_valid_o;
  logic      out_ready_i;
  logic      busy_o;

  integer      seed;
  logic [31:0] rnd;
  logic        rand_stall;  // Random out_ready_i instead of ready_fix
  logic        ready_fix;
  logic        full_rate;   // Every request must go in on its first cycle
  logic        lat_check;
  logic        hung;        // Some wait ran out of cycles
  logic        stall_q;     // Result was presented and not taken
  logic        busy_s;      // busy_o as sampled by the monitor
  cast_res_t   held_res;
  int          drv_idx;     // Table row currently on req_i
  int          cyc;
  int          errors;
  int          checks;
  int          idx_q[$];    // Rows in flight, oldest first
  int          cyc_q[$];    // Their acceptance cycles

  fp_cast_unit fp_cast_unit_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .res_o       (res_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin : clock
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i; // 20 ns period
  end

  always @(posedge clk_i) begin : ready_drive
    rnd = $random(seed);
    out_ready_i <= rand_stall ? rnd[0] : ready_fix;
  end

  task automatic check_val(input string name, input logic [63:0] exp_v,
                           input logic [63:0] got_v);
    checks++;
    if (got_v !== exp_v) begin
      $display("MISMATCH at %0t ns: %s expected %0h got %0h", $time, name, exp_v, got_v);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // Monitor, samples at the falling edge
  // --------------------------------------------------
  always @(negedge clk_i) begin : monitor
    int i;
    int c;
    if (rst_n_i) begin
      cyc++;
      busy_s = busy_o;
      if (stall_q) begin // Stalled result must not move
        check_val("out_valid_o", 1, out_valid_o);
        check_val("res_o", held_res, res_o);
      end
      stall_q  = out_valid_o && !out_ready_i && !flush_i;
      held_res = res_o;
      if (flush_i) begin
        idx_q.delete(); // Everything in flight is dropped
        cyc_q.delete();
      end else begin
        if (out_valid_o && out_ready_i) begin
          if (idx_q.size() == 0) begin
            $display("unexpected result %0h arrived with nothing outstanding", res_o.result);
            errors++;
          end else begin
            i = idx_q.pop_front();
            c = cyc_q.pop_front();
            check_val($sformatf("res_o.result row %0d", i), VECS[i].res, res_o.result);
            check_val($sformatf("res_o.status row %0d", i), VECS[i].st, res_o.status);
            if (lat_check) check_val("latency", 2, cyc - c);
          end
        end
        if (in_valid_i && in_ready_o) begin
          idx_q.push_back(drv_idx);
          cyc_q.push_back(cyc);
        end
      end
    end
  end

  // Present one row and hold it until the DUT takes it
  task automatic send(input int idx);
    int waited;
    waited = 0;
    if (hung) return;
    @(posedge clk_i);
    req_i.operand     <= VECS[idx].operand;
    req_i.op          <= VECS[idx].op;
    req_i.is_unsigned <= VECS[idx].uns;
    req_i.rnd_mode    <= VECS[idx].rm;
    in_valid_i        <= 1'b1;
    drv_idx           <= idx;
    @(negedge clk_i);
    while (!in_ready_o) begin
      if (waited == LIMIT) begin
        $display("timeout: request for row %0d was never accepted", idx);
        hung = 1'b1;
        return;
      end
      waited++;
      @(negedge clk_i);
    end
    if (full_rate && waited != 0) begin
      $display("row %0d was held back %0d cycles at full rate", idx, waited);
      errors++;
    end
  endtask

  task automatic end_burst();
    @(posedge clk_i); // Last request goes in on this edge
    in_valid_i <= 1'b0;
  endtask

  task automatic wait_idle(input string what);
    int n;
    n = 0;
    if (hung) return;
    @(posedge clk_i);
    while (idx_q.size() != 0 || busy_s) begin
      if (n == LIMIT) begin
        $display("timeout: %s did not drain, %0d results never came", what, idx_q.size());
        hung = 1'b1;
        return;
      end
      n++;
      @(posedge clk_i);
    end
  endtask

  task automatic run_table(input string what);
    for (int i = 0; i < N_VEC; i++) send(i);
    end_burst();
    wait_idle(what);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : main
    int e0;
    seed        = 32'he9f21329;
    rst_n_i     = 1'b0;
    req_i       = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b0;
    rand_stall  = 1'b0;
    ready_fix   = 1'b1;
    full_rate   = 1'b0;
    lat_check   = 1'b0;
    hung        = 1'b0;
    stall_q     = 1'b0;
    busy_s      = 1'b0;
    drv_idx     = 0;
    cyc         = 0;
    errors      = 0;
    checks      = 0;

    e0 = errors;
    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    check_val("in_ready_o", 0, in_ready_o); // Held off during reset
    @(posedge clk_i);
    rst_n_i <= 1'b1;                        // Eighth edge
    @(negedge clk_i);
    check_val("out_valid_o", 0, out_valid_o);
    check_val("busy_o", 0, busy_o);
    check_val("res_o", 0, res_o);
    repeat (2) @(posedge clk_i);
    $display("test 1 reset: %0d errors", errors - e0);

    // Back to back, result two edges after acceptance
    e0 = errors;
    full_rate = 1'b1;
    lat_check = 1'b1;
    run_table("full rate table");
    full_rate = 1'b0;
    lat_check = 1'b0;
    $display("test 2 full rate: %0d errors", errors - e0);

    e0 = errors;
    @(negedge clk_i);
    rand_stall = 1'b1;
    run_table("stalled table");
    @(negedge clk_i);
    rand_stall = 1'b0;
    $display("test 3 random stalls: %0d errors", errors - e0);

    // Fill both stages, then flush them away
    e0 = errors;
    @(negedge clk_i);
    ready_fix = 1'b0;
    send(13);
    send(14);
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    flush_i    <= 1'b1;
    @(negedge clk_i);
    check_val("in_ready_o", 0, in_ready_o);
    check_val("busy_o", 1, busy_o);
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    check_val("out_valid_o", 0, out_valid_o);
    check_val("busy_o", 0, busy_o);
    ready_fix = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_val("out_valid_o", 0, out_valid_o); // Nothing stale shows up
    end
    send(22);
    end_burst();
    wait_idle("request after flush");
    $display("test 4 flush: %0d errors", errors - e0);

    $display("summary: 4 tests, %0d checks, %0d errors, timed out %0d", checks, errors, hung);
    if (errors == 0 && !hung)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- tb.f
+incdir+logic
logic/cast_fmt_pkg.sv
logic/cast_op_pkg.sv
logic/cast_pipe_ctrl.sv
logic/cast_normalize.sv
logic/cast_align.sv
logic/cast_round_pack.sv
logic/fp_cast_unit.sv
sim/tb_fp_cast_unit.sv

//--- Bender.yml
package:
  name: fp_cast_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/cast_fmt_pkg.sv
      - logic/cast_op_pkg.sv
      - logic/cast_pipe_ctrl.sv
      - logic/cast_normalize.sv
      - logic/cast_align.sv
      - logic/cast_round_pack.sv
      - logic/fp_cast_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - sim/tb_fp_cast_unit.sv
